// File: hdl/spatz_macros.svh
/*
 * Global sizes and vector CSR addresses of the configuration front end.
 * Include this header in every file that needs one of these values.
 */

`ifndef SPATZ_MACROS_SVH
`define SPATZ_MACROS_SVH

// Datapath sizes
`define SPATZ_ELEN  32
`define SPATZ_VLEN  256
`define SPATZ_VLENB (`SPATZ_VLEN / 8)

// Longest vl: smallest element width at the largest multiplier
`define SPATZ_MAXVL 256

// Vector CSR addresses
`define SPATZ_CSR_VSTART 12'h008
`define SPATZ_CSR_VL     12'hC20
`define SPATZ_CSR_VTYPE  12'hC21
`define SPATZ_CSR_VLENB  12'hC22

`endif

// File: hdl/spatz_pkg.sv
/*
 * Types shared by the decoder, the vl calculator and the vector CSR block.
 * Modules import it inside their body and use scoped names in their ports.
 */

`default_nettype none

`include "spatz_macros.svh"

package spatz_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] instr_t;

	// Scalar operand and result
	typedef logic [`SPATZ_ELEN-1:0] elen_t;

	// Holds any vl or vstart up to MAXVL inclusive
	typedef logic [$clog2(`SPATZ_MAXVL+1)-1:0] vlen_t;

	//////////////////////////////////////////////////////////////////////
	// vtype fields
	//////////////////////////////////////////////////////////////////////

	// Element width, codes 4 to 7 are reserved
	typedef enum logic [2:0] {
		EW_8    = 3'd0,
		EW_16   = 3'd1,
		EW_32   = 3'd2,
		EW_64   = 3'd3,
		EW_RES4 = 3'd4,
		EW_RES5 = 3'd5,
		EW_RES6 = 3'd6,
		EW_RES7 = 3'd7
	} vew_e;

	// Register group multiplier, upper half is fractional
	typedef enum logic [2:0] {
		LMUL_1   = 3'd0,
		LMUL_2   = 3'd1,
		LMUL_4   = 3'd2,
		LMUL_8   = 3'd3,
		LMUL_RES = 3'd4,
		LMUL_F8  = 3'd5,
		LMUL_F4  = 3'd6,
		LMUL_F2  = 3'd7
	} vlmul_e;

	// Low byte of vtype, same layout as the zimm field
	typedef struct packed {
		logic   vma;
		logic   vta;
		vew_e   vsew;
		vlmul_e vlmul;
	} vtype_bits_t;

	//////////////////////////////////////////////////////////////////////
	// Decoded operation
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_NONE     = 3'd0,
		OP_VCFG     = 3'd1,
		OP_CSR_READ = 3'd2
	} spatz_op_e;

endpackage : spatz_pkg

`default_nettype wire

// File: hdl/spatz_decoder.sv
/*
 * Combinational decoder for vsetvli, vsetivli, vsetvl and csrrs reads of
 * the vector CSRs. Flags anything else as illegal while the strobe is high.
 */

`timescale 1ns/1ns
`default_nettype none

`include "spatz_macros.svh"

module spatz_decoder (
	input  spatz_pkg::instr_t      instr_i,
	input  logic                   instr_valid_i,
	input  spatz_pkg::elen_t       rs1_i,
	input  spatz_pkg::elen_t       rs2_i,
	output logic                   instr_illegal_o,
	output spatz_pkg::spatz_op_e   op_o,
	output spatz_pkg::vtype_bits_t vtype_o,
	output spatz_pkg::elen_t       avl_o,
	output logic                   keep_vl_o,
	output logic [11:0]            csr_addr_o
);
	import spatz_pkg::*;

	// Major opcodes and funct3 values
	localparam logic [6:0] OPC_OP_V   = 7'b1010111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
	localparam logic [2:0] F3_OPCFG   = 3'b111;
	localparam logic [2:0] F3_CSRRS   = 3'b010;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [11:0] csr;

	// Set for the two forms that take the length from rs1
	logic        uses_rs1;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign rd     = instr_i[11:7];
	assign rs1    = instr_i[19:15];
	assign csr    = instr_i[31:20];

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		instr_illegal_o = 1'b0;
		op_o            = OP_NONE;
		vtype_o         = '0;
		avl_o           = '0;
		keep_vl_o       = 1'b0;
		csr_addr_o      = '0;
		uses_rs1        = 1'b0;

		if (instr_valid_i) begin
			if (opcode == OPC_OP_V && funct3 == F3_OPCFG) begin
				// Bits 31:30 select the configuration form
				case (instr_i[31:30])
					2'b00, 2'b01: begin
						// vsetvli
						op_o     = OP_VCFG;
						vtype_o  = vtype_bits_t'(instr_i[27:20]);
						uses_rs1 = 1'b1;
					end
					2'b11: begin
						// vsetivli, length is the 5-bit uimm in the rs1 slot
						op_o    = OP_VCFG;
						vtype_o = vtype_bits_t'(instr_i[27:20]);
						avl_o   = elen_t'(rs1);
					end
					default: begin
						// vsetvl, remaining funct7 bits must be zero
						if (instr_i[29:25] == '0) begin
							op_o     = OP_VCFG;
							vtype_o  = vtype_bits_t'(rs2_i[7:0]);
							uses_rs1 = 1'b1;
						end else begin
							instr_illegal_o = 1'b1;
						end
					end
				endcase

				// rs1 = x0 requests VLMAX, or keeps vl when rd is x0 too
				if (uses_rs1) begin
					if (rs1 != '0) begin
						avl_o = rs1_i;
					end else if (rd != '0) begin
						avl_o = '1;
					end else begin
						keep_vl_o = 1'b1;
					end
				end
			end else if (opcode == OPC_SYSTEM && funct3 == F3_CSRRS && rs1 == '0) begin
				// Pure CSR read
				case (csr)
					`SPATZ_CSR_VSTART,
					`SPATZ_CSR_VL,
					`SPATZ_CSR_VTYPE,
					`SPATZ_CSR_VLENB: begin
						op_o       = OP_CSR_READ;
						csr_addr_o = csr;
					end
					default: begin
						instr_illegal_o = 1'b1;
					end
				endcase
			end else begin
				instr_illegal_o = 1'b1;
			end
		end
	end

endmodule : spatz_decoder

`default_nettype wire

// File: hdl/spatz_vl_calc.sv
/*
 * Checks a requested vtype and computes VLMAX and the new vl for it.
 * Pure logic, the CSR block decides whether the result is stored.
 */

`timescale 1ns/1ns
`default_nettype none

`include "spatz_macros.svh"

module spatz_vl_calc (
	input  spatz_pkg::vtype_bits_t vtype_i,
	input  spatz_pkg::elen_t       avl_i,
	input  logic                   keep_vl_i,
	input  spatz_pkg::vtype_bits_t vtype_q_i,
	input  logic                   vill_q_i,
	output logic                   vill_o,
	output spatz_pkg::vlen_t       vl_o,
	output spatz_pkg::vtype_bits_t vtype_o
);
	import spatz_pkg::*;

	// log2 of the SEW/LMUL ratio, minus the constant 3
	function automatic logic signed [4:0] ratio_log2(vtype_bits_t vt);
		logic [2:0] lmul_bits;
		lmul_bits = vt.vlmul;
		return $signed({2'b00, vt.vsew}) - $signed({{2{lmul_bits[2]}}, lmul_bits});
	endfunction

	logic [1:0] frac_shift;
	logic       vtype_bad;
	vlen_t      vlmax;

	//////////////////////////////////////////////////////////////////////
	// vtype check and VLMAX
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		frac_shift = 2'd0;
		vlmax      = vlen_t'(`SPATZ_VLENB) >> vtype_i.vsew;
		case (vtype_i.vlmul)
			LMUL_2:  vlmax = vlmax << 1;
			LMUL_4:  vlmax = vlmax << 2;
			LMUL_8:  vlmax = vlmax << 3;
			LMUL_F2: frac_shift = 2'd1;
			LMUL_F4: frac_shift = 2'd2;
			LMUL_F8: frac_shift = 2'd3;
			default: ;
		endcase
		vlmax = vlmax >> frac_shift;
	end

	// SEW/LMUL must not exceed ELEN for fractional groups
	assign vtype_bad = (vtype_i.vsew > EW_32) || (vtype_i.vlmul == LMUL_RES) ||
		((4'(vtype_i.vsew) + 4'(frac_shift) + 4'd3) > 4'($clog2(`SPATZ_ELEN)));

	//////////////////////////////////////////////////////////////////////
	// New vl
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		vill_o  = 1'b0;
		vtype_o = vtype_i;
		vl_o    = '0;
		if (vtype_bad) begin
			vill_o  = 1'b1;
			vtype_o = '0;
		end else if (keep_vl_i) begin
			// vl stays in the CSR block only if the ratio is unchanged
			if (vill_q_i || (ratio_log2(vtype_i) != ratio_log2(vtype_q_i))) begin
				vill_o  = 1'b1;
				vtype_o = '0;
			end
		end else if (avl_i == '1) begin
			vl_o = vlmax;
		end else if (avl_i < elen_t'(vlmax)) begin
			vl_o = vlen_t'(avl_i);
		end else begin
			vl_o = vlmax;
		end
	end

	a_vl_below_maxvl: assert final (vl_o <= `SPATZ_MAXVL)
		else $error("vl_calc produced vl %0d above MAXVL", vl_o);

endmodule : spatz_vl_calc

`default_nettype wire

// File: hdl/spatz_vcsr.sv
/*
 * Vector CSR state: vstart, vl, vtype and vill, plus the registered
 * scalar result. Loads on a configuration and answers CSR reads.
 */

`timescale 1ns/1ns
`default_nettype none

`include "spatz_macros.svh"

module spatz_vcsr (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  spatz_pkg::spatz_op_e   op_i,
	input  logic                   keep_vl_i,
	input  logic [11:0]            csr_addr_i,
	input  logic                   cfg_vill_i,
	input  spatz_pkg::vlen_t       cfg_vl_i,
	input  spatz_pkg::vtype_bits_t cfg_vtype_i,
	output spatz_pkg::vtype_bits_t vtype_q_o,
	output logic                   vill_q_o,
	output spatz_pkg::elen_t       rd_o
);
	import spatz_pkg::*;

	vlen_t       vstart_q;
	vlen_t       vl_q;
	vlen_t       vl_d;
	vtype_bits_t vtype_q;
	logic        vill_q;
	elen_t       rd_q;
	elen_t       rd_d;

	//////////////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////////////

	// Keep-vl form holds vl, an illegal vtype still clears it
	assign vl_d = (keep_vl_i && !cfg_vill_i) ? vl_q : cfg_vl_i;

	always_comb begin
		rd_d = rd_q;
		case (op_i)
			OP_VCFG: begin
				rd_d = elen_t'(vl_d);
			end
			OP_CSR_READ: begin
				case (csr_addr_i)
					`SPATZ_CSR_VSTART: rd_d = elen_t'(vstart_q);
					`SPATZ_CSR_VL:     rd_d = elen_t'(vl_q);
					// vill sits in the top bit
					`SPATZ_CSR_VTYPE:  rd_d = {vill_q, {(`SPATZ_ELEN - 9){1'b0}}, vtype_q};
					`SPATZ_CSR_VLENB:  rd_d = elen_t'(`SPATZ_VLENB);
					default:           rd_d = rd_q;
				endcase
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			// vstart only ever holds its reset value here
			vstart_q <= '0;
			vl_q     <= '0;
			vtype_q  <= '0;
			vill_q   <= 1'b1;
			rd_q     <= '0;
		end else begin
			if (op_i == OP_VCFG) begin
				vl_q    <= vl_d;
				vtype_q <= cfg_vtype_i;
				vill_q  <= cfg_vill_i;
			end
			rd_q <= rd_d;
		end
	end

	assign vtype_q_o = vtype_q;
	assign vill_q_o  = vill_q;
	assign rd_o      = rd_q;

	// An illegal configuration never leaves a stale length behind
	a_vl_zero_on_vill: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) vill_q |-> (vl_q == '0)
	) else $error("vl is %0d while vill is set", vl_q);

	a_op_known: assert property (
		@(posedge clk_i) disable iff (!arst_n_i) !$isunknown(op_i)
	) else $error("decoded operation is unknown");

endmodule : spatz_vcsr

`default_nettype wire

// File: hdl/spatz.sv
/*
 * Top of the vector configuration front end. One instruction per strobe,
 * illegal flag in the same cycle, scalar result one cycle later.
 */

`timescale 1ns/1ns
`default_nettype none

module spatz (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  spatz_pkg::instr_t instr_i,
	input  logic              instr_valid_i,
	input  spatz_pkg::elen_t  rs1_i,
	input  spatz_pkg::elen_t  rs2_i,
	output logic              instr_illegal_o,
	output spatz_pkg::elen_t  rd_o
);
	import spatz_pkg::*;

	// Decoded request
	spatz_op_e   op;
	vtype_bits_t vtype_req;
	elen_t       avl;
	logic        keep_vl;
	logic [11:0] csr_addr;

	// Calculated configuration and current state
	logic        cfg_vill;
	vlen_t       cfg_vl;
	vtype_bits_t cfg_vtype;
	vtype_bits_t vtype_q;
	logic        vill_q;

	spatz_decoder i_decoder (
		.instr_i         (instr_i),
		.instr_valid_i   (instr_valid_i),
		.rs1_i           (rs1_i),
		.rs2_i           (rs2_i),
		.instr_illegal_o (instr_illegal_o),
		.op_o            (op),
		.vtype_o         (vtype_req),
		.avl_o           (avl),
		.keep_vl_o       (keep_vl),
		.csr_addr_o      (csr_addr)
	);

	spatz_vl_calc i_vl_calc (
		.vtype_i   (vtype_req),
		.avl_i     (avl),
		.keep_vl_i (keep_vl),
		.vtype_q_i (vtype_q),
		.vill_q_i  (vill_q),
		.vill_o    (cfg_vill),
		.vl_o      (cfg_vl),
		.vtype_o   (cfg_vtype)
	);

	spatz_vcsr i_vcsr (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.op_i        (op),
		.keep_vl_i   (keep_vl),
		.csr_addr_i  (csr_addr),
		.cfg_vill_i  (cfg_vill),
		.cfg_vl_i    (cfg_vl),
		.cfg_vtype_i (cfg_vtype),
		.vtype_q_o   (vtype_q),
		.vill_q_o    (vill_q),
		.rd_o        (rd_o)
	);

endmodule : spatz

`default_nettype wire

// File: verification/tb_spatz.sv
/*
 * Directed testbench for the vector configuration front end. Drives encoded
 * instructions into the DUT, predicts vl, vtype and vill with its own model.
 */

`timescale 1ns/1ns
`default_nettype none

`include "spatz_macros.svh"

module tb_spatz;

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam logic [6:0] OPC_OP_V = 7'b1010111;

	logic        clk;
	logic        arst_n;
	logic [31:0] instr;
	logic        instr_valid;
	logic [31:0] rs1;
	logic [31:0] rs2;
	logic        instr_illegal;
	logic [31:0] rd;

	// Reference state
	int          exp_vl;
	logic        exp_vill;
	logic [7:0]  exp_vtype;
	logic [31:0] exp_rd;
	int          errors;
	int          checks;
	integer      seed;

	spatz i_spatz (
		.clk_i           (clk),
		.arst_n_i        (arst_n),
		.instr_i         (instr),
		.instr_valid_i   (instr_valid),
		.rs1_i           (rs1),
		.rs2_i           (rs2),
		.instr_illegal_o (instr_illegal),
		.rd_o            (rd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_vsetvli(logic [4:0] rd_r, logic [4:0] rs1_r,
			logic [7:0] zimm);
		return {4'b0000, zimm, rs1_r, 3'b111, rd_r, OPC_OP_V};
	endfunction

	function automatic logic [31:0] enc_vsetivli(logic [4:0] rd_r, logic [4:0] uimm,
			logic [7:0] zimm);
		return {4'b1100, zimm, uimm, 3'b111, rd_r, OPC_OP_V};
	endfunction

	function automatic logic [31:0] enc_vsetvl(logic [4:0] rd_r, logic [4:0] rs1_r,
			logic [4:0] rs2_r);
		return {7'b1000000, rs2_r, rs1_r, 3'b111, rd_r, OPC_OP_V};
	endfunction

	// csrrs rd, csr, x0
	function automatic logic [31:0] enc_csr_read(logic [4:0] rd_r, logic [11:0] csr);
		return {csr, 5'd0, 3'b010, rd_r, 7'b1110011};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic bit vtype_legal(logic [7:0] vt);
		int sew_code;
		int lmul_code;
		sew_code  = vt[5:3];
		lmul_code = vt[2:0];
		if (sew_code > 2 || lmul_code == 4)
			return 1'b0;
		// Fractional LMUL must hold SEW within ELEN
		if (lmul_code > 4 && ((8 << sew_code) << (8 - lmul_code)) > `SPATZ_ELEN)
			return 1'b0;
		return 1'b1;
	endfunction

	function automatic int vlmax_of(logic [7:0] vt);
		int vlmax;
		vlmax = `SPATZ_VLEN / (8 << vt[5:3]);
		if (vt[2:0] < 4)
			vlmax = vlmax << vt[2:0];
		else
			vlmax = vlmax >> (8 - vt[2:0]);
		return vlmax;
	endfunction

	// log2(SEW / LMUL)
	function automatic int ratio_log2(logic [7:0] vt);
		int lmul_log2;
		lmul_log2 = (vt[2:0] < 4) ? vt[2:0] : int'(vt[2:0]) - 8;
		return int'(vt[5:3]) + 3 - lmul_log2;
	endfunction

	function automatic int expected_vl(logic [7:0] vt, logic [31:0] avl);
		if (avl == 32'hFFFF_FFFF || avl >= 32'(vlmax_of(vt)))
			return vlmax_of(vt);
		return int'(avl);
	endfunction

	task automatic model_cfg(input logic [7:0] vt, input logic [31:0] avl, input bit keep);
		bit reject;
		reject = !vtype_legal(vt) ||
			(keep && (exp_vill || ratio_log2(vt) != ratio_log2(exp_vtype)));
		if (reject) begin
			exp_vill  = 1'b1;
			exp_vl    = 0;
			exp_vtype = '0;
		end else begin
			exp_vill  = 1'b0;
			exp_vtype = vt;
			if (!keep)
				exp_vl = expected_vl(vt, avl);
		end
		exp_rd = 32'(exp_vl);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving and checking
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			errors++;
			$display("mismatch at %0t ns: %s expected 0x%08h got 0x%08h", $time, name,
				exp_v, act_v);
		end
	endtask

	// Called 1 ns after a rising edge, returns 1 ns after the next one
	task automatic exec(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
			input logic exp_illegal);
		instr       = ins;
		rs1         = a;
		rs2         = b;
		instr_valid = 1'b1;
		#2;
		check_value("instr_illegal_o", 32'(exp_illegal), 32'(instr_illegal));
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic read_and_check(input logic [11:0] csr, input logic [31:0] exp_v,
			input string name);
		exec(enc_csr_read(5'd3, csr), '0, '0, 1'b0);
		exp_rd = exp_v;
		check_value(name, exp_v, rd);
	endtask

	task automatic check_state();
		read_and_check(`SPATZ_CSR_VL, 32'(exp_vl), "vl");
		read_and_check(`SPATZ_CSR_VTYPE, {exp_vill, 23'd0, exp_vtype}, "vtype");
	endtask

	task automatic cfg_and_check(input logic [31:0] ins, input logic [31:0] a,
			input logic [31:0] b, input logic [7:0] vt, input logic [31:0] avl, input bit keep);
		exec(ins, a, b, 1'b0);
		model_cfg(vt, avl, keep);
		check_value("rd_o after config", exp_rd, rd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_reads();
		check_value("rd_o after reset", 32'd0, rd);
		read_and_check(`SPATZ_CSR_VL, 32'd0, "vl after reset");
		read_and_check(`SPATZ_CSR_VSTART, 32'd0, "vstart after reset");
		read_and_check(`SPATZ_CSR_VTYPE, 32'h8000_0000, "vtype after reset");
		read_and_check(`SPATZ_CSR_VLENB, 32'd32, "vlenb");
	endtask

	task automatic test_sweep();
		logic [7:0]  vt;
		logic [31:0] avl;
		for (int i = 0; i < 64; i++) begin
			vt  = {2'($random(seed)), i[5:0]};
			avl = $random(seed);
			// Mostly lengths near VLMAX and now and then a full-width value
			if (i % 4 != 3)
				avl = avl % 300;
			cfg_and_check(enc_vsetvli(5'd1, 5'd10, vt), avl, '0, vt, avl, 1'b0);
			check_state();
			avl = $unsigned($random(seed)) % 300;
			cfg_and_check(enc_vsetvl(5'd2, 5'd10, 5'd11), avl, {24'd0, vt}, vt, avl, 1'b0);
			check_state();
		end
	endtask

	task automatic test_immediate();
		logic [7:0] vt;
		for (int i = 0; i < 32; i++) begin
			vt = {2'b00, 3'(i % 3), 3'(i % 4)};
			cfg_and_check(enc_vsetivli(5'd1, 5'(i), vt), '0, '0, vt, 32'(i), 1'b0);
		end
		check_state();
		// rs1 = x0 with rd non-x0 asks for VLMAX
		cfg_and_check(enc_vsetvli(5'd1, 5'd0, 8'h13), 32'd5, '0, 8'h13, '1, 1'b0);
		cfg_and_check(enc_vsetvl(5'd4, 5'd0, 5'd11), 32'd7, 32'h0000_0007, 8'h07, '1, 1'b0);
		check_state();
	endtask

	task automatic test_reject();
		logic [7:0] bad_vt [3];
		bad_vt = '{8'h18, 8'h0C, 8'h15};
		foreach (bad_vt[i]) begin
			cfg_and_check(enc_vsetvli(5'd1, 5'd10, 8'h10), 32'd9, '0, 8'h10, 32'd9, 1'b0);
			cfg_and_check(enc_vsetvli(5'd1, 5'd10, bad_vt[i]), 32'd9, '0, bad_vt[i],
				32'd9, 1'b0);
			check_state();
		end
	endtask

	task automatic test_keep_vl();
		// e32 m1 then e16 mf2 share ratio 32
		cfg_and_check(enc_vsetvli(5'd1, 5'd10, 8'h10), 32'd5, '0, 8'h10, 32'd5, 1'b0);
		cfg_and_check(enc_vsetvli(5'd0, 5'd0, 8'h0F), '0, '0, 8'h0F, '0, 1'b1);
		check_state();
		// e8 m1 changes the ratio
		cfg_and_check(enc_vsetvli(5'd0, 5'd0, 8'h00), '0, '0, 8'h00, '0, 1'b1);
		check_state();
		// Still vill, so keep-vl cannot recover
		cfg_and_check(enc_vsetvli(5'd0, 5'd0, 8'h00), '0, '0, 8'h00, '0, 1'b1);
		check_state();
	endtask

	task automatic test_illegal();
		cfg_and_check(enc_vsetvli(5'd1, 5'd10, 8'h09), 32'd11, '0, 8'h09, 32'd11, 1'b0);
		exec(32'h0050_0093, '0, '0, 1'b1);
		check_value("rd_o after unknown opcode", exp_rd, rd);
		exec(enc_csr_read(5'd3, 12'h300), '0, '0, 1'b1);
		check_value("rd_o after unknown CSR", exp_rd, rd);
		#2;
		check_value("instr_illegal_o while idle", 32'd0, 32'(instr_illegal));
		check_state();
		read_and_check(`SPATZ_CSR_VSTART, 32'd0, "vstart");
	endtask

	initial begin
		seed        = 17269;
		errors      = 0;
		checks      = 0;
		exp_vl      = 0;
		exp_vill    = 1'b1;
		exp_vtype   = '0;
		exp_rd      = '0;
		arst_n      = 1'b0;
		instr       = '0;
		instr_valid = 1'b0;
		rs1         = '0;
		rs2         = '0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset_reads();
		test_sweep();
		test_immediate();
		test_reject();
		test_keep_vl();
		test_illegal();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Timeout: the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule : tb_spatz

`default_nettype wire

// File: spatz_cfg.f
+incdir+hdl
hdl/spatz_pkg.sv
hdl/spatz_decoder.sv
hdl/spatz_vl_calc.sv
hdl/spatz_vcsr.sv
hdl/spatz.sv
verification/tb_spatz.sv
